// ==== design/dekatronPkg.sv ====
package dekatronPkg;

	// ------------------------------------------------------------------------
	// register geometry
	// ------------------------------------------------------------------------

	localparam int digitCount = 3;                          // tubes in the chain.
	localparam int digitWidth = 4;                          // one BCD digit per tube.
	localparam int valueWidth = digitCount * digitWidth;

	// ------------------------------------------------------------------------
	// timing
	// ------------------------------------------------------------------------

	// the machine tick replaces the slow machine clock of the tube rack.
	localparam int tickDivide = 10;
	localparam int tickCountWidth = $clog2(tickDivide);

	// a glow step takes a few fast cycles, like the guide pulses of a real tube.
	localparam int stepCycles = 3;
	localparam int stepCountWidth = $clog2(stepCycles + 1);

	// wrap point of the register in top-limit mode, BCD 255.
	localparam logic [valueWidth-1:0] topValue = {4'd2, 4'd5, 4'd5};

	// ------------------------------------------------------------------------
	// command and status words
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic request;                  // level, raised only while ready is high.
		logic dec;                      // count down instead of up.
		logic set;                      // load value instead of counting.
		logic [valueWidth-1:0] value;   // BCD, tube 0 in the low digit.
	} counterCmd;

	typedef struct packed {
		logic ready;
		logic zero;
		logic [valueWidth-1:0] value;
	} counterStatus;

endpackage

// ==== design/machineTick.sv ====
module machineTick
	import dekatronPkg::*;
(
	input  logic hsClk,
	input  logic Rst_n,
	output logic tick
);

	logic [tickCountWidth-1:0] phase;
	logic lastPhase;

	// the tick marks the final cycle of each machine period.
	assign lastPhase = (phase == tickCountWidth'(tickDivide - 1));

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			phase <= '0;
		end else if (lastPhase) begin
			phase <= '0;                // start the next machine period.
		end else begin
			phase <= phase + 1'b1;
		end
	end

	assign tick = lastPhase;

endmodule

// ==== design/requestImpulse.sv ====
module requestImpulse (
	input  logic hsClk,
	input  logic Rst_n,
	input  logic tick,
	input  logic request,
	output logic cmdStrobe,
	output logic cmdWindow
);

	logic requestQ;
	logic requestRise;
	logic armed;
	logic windowOpen;

	// only a fresh rising level counts, so a held request fires once.
	assign requestRise = request & ~requestQ;

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			requestQ <= 1'b0;
			armed <= 1'b0;
			windowOpen <= 1'b0;
		end else begin
			requestQ <= request;
			if (requestRise) begin
				armed <= 1'b1;          // wait for the next machine tick.
			end else if (cmdStrobe) begin
				armed <= 1'b0;
			end
			if (cmdStrobe) begin
				windowOpen <= 1'b1;
			end else if (tick) begin
				windowOpen <= 1'b0;     // the window lasts one machine period.
			end
		end
	end

	assign cmdStrobe = tick & armed;

	// the closing tick is excluded so the window spans exactly tickDivide cycles.
	assign cmdWindow = cmdStrobe | (windowOpen & ~tick);

endmodule

// ==== design/dekatronTube.sv ====
module dekatronTube
	import dekatronPkg::*;
(
	input  logic hsClk,
	input  logic Rst_n,
	input  logic stepUp,
	input  logic stepDown,
	input  logic load,
	input  logic [digitWidth-1:0] loadDigit,
	input  logic [digitWidth-1:0] topDigit,
	output logic [digitWidth-1:0] digit,
	output logic zero,
	output logic topPin,
	output logic carryHigh,
	output logic carryLow,
	output logic busy
);

	localparam logic [digitWidth-1:0] lastCathode = digitWidth'(9);

	logic [digitWidth-1:0] position;            // cathode where the glow rests.
	logic [digitWidth-1:0] target;              // cathode the glow moves to.
	logic [digitWidth-1:0] nextCathode;
	logic [stepCountWidth-1:0] guideCount;
	logic loadTaken;
	logic loadStart;
	logic moveStart;

	// a load waits for an idle tube and is taken once per high level.
	assign loadStart = load & ~loadTaken & ~busy;
	assign moveStart = stepUp | stepDown | loadStart;

	always_comb begin
		if (loadStart) begin
			nextCathode = loadDigit;
		end else if (stepDown) begin
			if (position == '0) begin
				nextCathode = lastCathode;      // borrow, glow jumps from 0 to 9.
			end else begin
				nextCathode = position - 1'b1;
			end
		end else begin
			if (position == lastCathode) begin
				nextCathode = '0;
			end else begin
				nextCathode = position + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// guide phase
	// ------------------------------------------------------------------------

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			position <= '0;
			busy <= 1'b0;
			guideCount <= '0;
			loadTaken <= 1'b0;
		end else begin
			loadTaken <= load & (loadTaken | loadStart);
			if (moveStart) begin
				busy <= 1'b1;
				guideCount <= stepCountWidth'(stepCycles - 1);
			end else if (busy) begin
				if (guideCount == '0) begin
					busy <= 1'b0;
					position <= target;         // glow settles on the new cathode.
				end else begin
					guideCount <= guideCount - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge hsClk) begin
		if (moveStart) begin
			target <= nextCathode;
		end
	end

	// ------------------------------------------------------------------------
	// cathode pins
	// ------------------------------------------------------------------------

	assign digit = position;
	assign carryHigh = (position == lastCathode);   // next up step wraps.
	assign carryLow = (position == '0);             // next down step borrows.
	assign topPin = (position == topDigit);

	// zero reports a settled glow only.
	assign zero = (position == '0) & ~busy;

	// the counter must not pulse a tube that is still moving its glow.
	stepWhileBusy: assert property (@(posedge hsClk) disable iff (!Rst_n)
		(stepUp || stepDown) |-> !busy);

	stepBothWays: assert property (@(posedge hsClk) disable iff (!Rst_n)
		!(stepUp && stepDown));

endmodule

// ==== design/dekatronCounter.sv ====
module dekatronCounter
	import dekatronPkg::*;
#(
	parameter bit topLimitMode = 1'b0
) (
	input  logic hsClk,
	input  logic Rst_n,
	input  counterCmd cmd,
	input  logic cmdStrobe,
	input  logic cmdWindow,
	output counterStatus status
);

	logic [digitCount-1:0] stepUp;
	logic [digitCount-1:0] stepDown;
	logic [digitCount-1:0] zeros;
	logic [digitCount-1:0] topPins;
	logic [digitCount-1:0] carryHigh;
	logic [digitCount-1:0] carryLow;
	logic [digitCount-1:0] busy;
	logic [valueWidth-1:0] digits;
	logic [valueWidth-1:0] loadValue;
	logic [valueWidth-1:0] loadWord;
	logic [valueWidth-1:0] tubeLoad;
	logic allZero;
	logic atTop;
	logic wrapUp;
	logic wrapDown;
	logic loadNow;
	logic loadArmed;
	logic load;
	logic ready;

	assign allZero = &zeros;
	assign atTop = &topPins;

	// ------------------------------------------------------------------------
	// action selection
	// ------------------------------------------------------------------------

	// in top-limit mode the register runs from 000 to topValue and back.
	assign wrapUp = topLimitMode & ~cmd.set & ~cmd.dec & atTop;
	assign wrapDown = topLimitMode & ~cmd.set & cmd.dec & allZero;
	assign loadNow = cmd.set | wrapUp | wrapDown;

	always_comb begin
		if (cmd.set) begin
			loadValue = cmd.value;
		end else if (wrapDown) begin
			loadValue = topValue;
		end else begin
			loadValue = '0;             // wrap up from the top value.
		end
	end

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			loadArmed <= 1'b0;
		end else if (cmdStrobe) begin
			loadArmed <= loadNow;
		end else if (!cmdWindow) begin
			loadArmed <= 1'b0;
		end
	end

	// the tubes see the same digits for the whole load level.
	always_ff @(posedge hsClk) begin
		if (cmdStrobe) begin
			loadWord <= loadValue;
		end
	end

	assign load = cmdStrobe ? loadNow : (loadArmed & cmdWindow);
	assign tubeLoad = cmdStrobe ? loadValue : loadWord;

	// a count enters the low tube only, carries ripple up in the same cycle.
	assign stepUp[0] = cmdStrobe & ~loadNow & ~cmd.dec;
	assign stepDown[0] = cmdStrobe & ~loadNow & cmd.dec;

	// ------------------------------------------------------------------------
	// tube chain
	// ------------------------------------------------------------------------

	for (genvar d = 0; d < digitCount; d++) begin : tubeGen
		dekatronTube i_tube (
			.hsClk(hsClk),
			.Rst_n(Rst_n),
			.stepUp(stepUp[d]),
			.stepDown(stepDown[d]),
			.load(load),
			.loadDigit(tubeLoad[d*digitWidth +: digitWidth]),
			.topDigit(topValue[d*digitWidth +: digitWidth]),
			.digit(digits[d*digitWidth +: digitWidth]),
			.zero(zeros[d]),
			.topPin(topPins[d]),
			.carryHigh(carryHigh[d]),
			.carryLow(carryLow[d]),
			.busy(busy[d])
		);

		if (d < digitCount - 1) begin : rippleGen
			assign stepUp[d+1] = stepUp[d] & carryHigh[d];      // 9 to 0 carries.
			assign stepDown[d+1] = stepDown[d] & carryLow[d];   // 0 to 9 borrows.
		end
	end

	assign ready = ~cmdWindow & ~(|busy);
	assign status = '{ready: ready, zero: allZero, value: digits};

	loadStepExclusive: assert property (@(posedge hsClk) disable iff (!Rst_n)
		!(load && (stepUp[0] || stepDown[0])));

	// a new command may only start on an idle register.
	requestWhileBusy: assert property (@(posedge hsClk) disable iff (!Rst_n)
		$rose(cmd.request) |-> ready);

endmodule

// ==== design/dekatronUnit.sv ====
module dekatronUnit
	import dekatronPkg::*;
(
	input  logic hsClk,
	input  logic Rst_n,
	input  counterCmd cmd,
	output counterStatus status
);

	logic tick;
	logic cmdStrobe;
	logic cmdWindow;

	// machine period generator in place of the slow rack clock.
	machineTick i_machineTick (
		.hsClk(hsClk),
		.Rst_n(Rst_n),
		.tick(tick)
	);

	requestImpulse i_requestImpulse (
		.hsClk(hsClk),
		.Rst_n(Rst_n),
		.tick(tick),
		.request(cmd.request),
		.cmdStrobe(cmdStrobe),
		.cmdWindow(cmdWindow)
	);

	// the register wraps between 000 and topValue.
	dekatronCounter #(
		.topLimitMode(1'b1)
	) i_dekatronCounter (
		.hsClk(hsClk),
		.Rst_n(Rst_n),
		.cmd(cmd),
		.cmdStrobe(cmdStrobe),
		.cmdWindow(cmdWindow),
		.status(status)
	);

endmodule

// ==== tests/dekatronUnitTb.sv ====
module dekatronUnitTb
	import dekatronPkg::*;
;

	typedef enum logic [1:0] {opLoad, opUp, opDown} opKind;

	// one row of the operation table, values in decimal.
	typedef struct packed {
		opKind op;
		logic [7:0] arg;                // load value, unused for counting.
		logic [7:0] expected;           // register value after the command.
	} tableEntry;

	localparam int topDecimal = 255;
	localparam int tableSize = 22;
	localparam int randomOps = 40;
	localparam int readyLimit = 4 * tickDivide;
	localparam int riseLimit = 4 * tickDivide;

	logic hsClk = 1'b0;
	logic Rst_n;
	counterCmd cmd;
	counterStatus status;

	int checkErrors = 0;
	int timeoutErrors = 0;
	int cmdIndex = 0;
	int modelValue = 0;
	logic [16:0] lfsrState = 17'd93616;

	// loads, carries across tubes, borrows and both top-limit wraps.
	tableEntry opTable [tableSize] = '{
		'{opLoad, 8'd5, 8'd5},     '{opLoad, 8'd0, 8'd0},     '{opLoad, 8'd99, 8'd99},
		'{opUp, 8'd0, 8'd100},     '{opDown, 8'd0, 8'd99},    '{opLoad, 8'd199, 8'd199},
		'{opUp, 8'd0, 8'd200},     '{opLoad, 8'd10, 8'd10},   '{opDown, 8'd0, 8'd9},
		'{opLoad, 8'd254, 8'd254}, '{opUp, 8'd0, 8'd255},     '{opUp, 8'd0, 8'd0},
		'{opDown, 8'd0, 8'd255},   '{opDown, 8'd0, 8'd254},   '{opLoad, 8'd0, 8'd0},
		'{opDown, 8'd0, 8'd255},   '{opUp, 8'd0, 8'd0},       '{opLoad, 8'd9, 8'd9},
		'{opUp, 8'd0, 8'd10},      '{opLoad, 8'd255, 8'd255}, '{opLoad, 8'd128, 8'd128},
		'{opDown, 8'd0, 8'd127}
	};

	dekatronUnit i_dekatronUnit (
		.hsClk(hsClk),
		.Rst_n(Rst_n),
		.cmd(cmd),
		.status(status)
	);

	always #4 hsClk = ~hsClk;

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	function automatic logic [valueWidth-1:0] toBcd(input int value);
		logic [valueWidth-1:0] bcd;
		int rest;
		rest = value;
		for (int d = 0; d < digitCount; d++) begin
			bcd[d*digitWidth +: digitWidth] = digitWidth'(rest % 10);
			rest = rest / 10;
		end
		return bcd;
	endfunction

	// the register wraps between 000 and the top value in both directions.
	function automatic int stepModel(input int current, input opKind op, input int arg);
		case (op)
			opLoad: return arg;
			opUp: return (current == topDecimal) ? 0 : current + 1;
			default: return (current == 0) ? topDecimal : current - 1;
		endcase
	endfunction

	function automatic logic [16:0] lfsrNext(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};    // taps 17 and 14.
	endfunction

	task automatic drawBits(input int count, output int result);
		result = 0;
		for (int b = 0; b < count; b++) begin
			lfsrState = lfsrNext(lfsrState);
			result = (result << 1) | int'(lfsrState[0]);
		end
	endtask

	// ------------------------------------------------------------------------
	// command sequencing
	// ------------------------------------------------------------------------

	task automatic checkResult(input int expected);
		logic [valueWidth-1:0] want;
		want = toBcd(expected);
		if (status.value !== want) begin
			$display("[FAIL] %0t status.value expected %h got %h", $time, want, status.value);
			checkErrors++;
		end
		if (status.zero !== (expected == 0)) begin
			$display("[FAIL] %0t status.zero expected %b got %b", $time, expected == 0,
				status.zero);
			checkErrors++;
		end
	endtask

	task automatic runCommand(input opKind op, input int arg, input int expected);
		counterCmd nextCmd;
		int waited;
		int lowCycles;
		bit seen;
		seen = 1'b0;
		for (waited = 0; waited < readyLimit && !seen; waited++) begin
			@(negedge hsClk);
			seen = status.ready;
		end
		if (!seen) begin
			$display("command %0d never saw ready before it could start", cmdIndex);
			timeoutErrors++;
			return;
		end
		nextCmd = '0;
		nextCmd.request = 1'b1;
		nextCmd.dec = (op == opDown);
		nextCmd.set = (op == opLoad);
		nextCmd.value = (op == opLoad) ? toBcd(arg) : '0;
		@(posedge hsClk);
		cmd <= nextCmd;
		seen = 1'b0;
		for (waited = 0; waited < tickDivide + 2 && !seen; waited++) begin
			@(negedge hsClk);
			seen = !status.ready;
		end
		if (!seen) begin
			$display("command %0d was not accepted, ready stayed high", cmdIndex);
			timeoutErrors++;
			return;
		end
		lowCycles = 1;
		seen = 1'b0;
		for (waited = 0; waited < riseLimit && !seen; waited++) begin
			@(posedge hsClk);
			cmd.request <= 1'b0;        // dec, set and value stay until ready.
			@(negedge hsClk);
			if (status.ready) begin
				seen = 1'b1;
			end else begin
				lowCycles++;
			end
		end
		if (!seen) begin
			$display("command %0d never finished, ready stayed low", cmdIndex);
			timeoutErrors++;
			return;
		end
		if (lowCycles < tickDivide) begin
			$display("[FAIL] %0t ready low cycles expected %0d got %0d", $time, tickDivide,
				lowCycles);
			checkErrors++;
		end
		checkResult(expected);
		cmdIndex++;
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		tableEntry entry;
		opKind op;
		int pick;
		int arg;
		cmd <= '0;
		Rst_n <= 1'b0;
		repeat (16) @(posedge hsClk);
		Rst_n <= 1'b1;
		@(negedge hsClk);
		if (status.ready !== 1'b1) begin
			$display("[FAIL] %0t status.ready expected 1 got %b", $time, status.ready);
			checkErrors++;
		end
		checkResult(0);

		for (int i = 0; i < tableSize; i++) begin
			entry = opTable[i];
			modelValue = stepModel(modelValue, entry.op, int'(entry.arg));
			if (modelValue != int'(entry.expected)) begin
				$display("table row %0d does not follow the counting rules", i);
				checkErrors++;
			end
			runCommand(entry.op, int'(entry.arg), int'(entry.expected));
		end

		// random mix, load values stay within the top-limit range.
		for (int i = 0; i < randomOps; i++) begin
			drawBits(2, pick);
			arg = 0;
			if (pick == 0) begin
				op = opLoad;
				drawBits(8, arg);
			end else if (pick == 2) begin
				op = opDown;
			end else begin
				op = opUp;
			end
			modelValue = stepModel(modelValue, op, arg);
			runCommand(op, arg, modelValue);
		end

		$display("commands: %0d, failed checks: %0d, timeouts: %0d", cmdIndex, checkErrors,
			timeoutErrors);
		if (checkErrors == 0 && timeoutErrors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== list.f ====
design/dekatronPkg.sv
design/machineTick.sv
design/requestImpulse.sv
design/dekatronTube.sv
design/dekatronCounter.sv
design/dekatronUnit.sv
tests/dekatronUnitTb.sv

// ==== Makefile ====
TOP = dekatronUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# the run passes only when the testbench prints its pass line.
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
